/* src/lsu_defines.svh */
// set index covers paddr[11:4] with 16-byte lines; pages are fixed at 4 KiB, no huge pages
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// cache geometry
`define LSU_SET_BITS 8
`define LSU_WAYS 4

// fully associative TLB depth
`define LSU_TLB_ENTRIES 4

// exception codes, lower value wins when several apply
`define LSU_EXC_NONE 3'd0
`define LSU_EXC_ALE 3'd1
`define LSU_EXC_TLBR 3'd2
`define LSU_EXC_INV 3'd3
`define LSU_EXC_PPI 3'd4
`define LSU_EXC_PME 3'd5

`endif

/* src/lsu_pkg.sv */
// types only; physical page is 20 bits, so physical addresses are limited to 32 bits
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    // one tag word per set and way
    typedef struct packed {
        logic        valid;
        logic [10:0] spare;  // ignored by the hit compare
        logic [19:0] ppn;
    } tag_entry_t;

    // snoop word, tag view when snoop kind is 1
    typedef union packed {
        tag_entry_t  tag;
        logic [31:0] word;
    } snoop_payload_u;

    typedef struct packed {
        logic        valid;
        logic [19:0] vppn;
        logic [19:0] ppn;
        logic        v;     // page valid
        logic        d;     // dirty, stores allowed
        logic [1:0]  plv;
        logic [1:0]  mat;   // 0 is uncached
    } tlb_entry_t;

    typedef enum logic [2:0] {
        EXC_NONE = `LSU_EXC_NONE,
        EXC_ALE  = `LSU_EXC_ALE,
        EXC_TLBR = `LSU_EXC_TLBR,
        EXC_INV  = `LSU_EXC_INV,
        EXC_PPI  = `LSU_EXC_PPI,
        EXC_PME  = `LSU_EXC_PME
    } exc_code_e;

endpackage

`default_nettype wire

/* src/lsu_addr_trans.sv */
// duplicate vppn entries are not allowed, their fields would be OR-ed together on a hit
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_addr_trans (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic [31:0]                          vaddr_i,
    input  wire logic                                 tlb_we_i,
    input  wire logic [$clog2(`LSU_TLB_ENTRIES)-1:0]  tlb_idx_i,
    input  wire lsu_pkg::tlb_entry_t                  tlb_entry_i,
    input  wire logic                                 hold_i,
    output logic                                      found_o,
    output lsu_pkg::tlb_entry_t                       entry_o
);
    import lsu_pkg::*;

    tlb_entry_t entries_q [`LSU_TLB_ENTRIES];
    tlb_entry_t cur_entry;
    tlb_entry_t hit_entry;
    logic       hit_any;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LSU_TLB_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (tlb_we_i) begin
            entries_q[tlb_idx_i] <= tlb_entry_i;
        end
    end

    // compare all entries, a same-cycle update is seen by the lookup
    always_comb begin
        hit_any   = 1'b0;
        hit_entry = '0;
        cur_entry = '0;
        for (int i = 0; i < `LSU_TLB_ENTRIES; i++) begin
            cur_entry = (tlb_we_i && int'(tlb_idx_i) == i) ? tlb_entry_i : entries_q[i];
            if (cur_entry.valid && cur_entry.vppn == vaddr_i[31:12]) begin
                hit_any   = 1'b1;
                hit_entry = hit_entry | cur_entry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            found_o <= 1'b0;
        end else if (!hold_i) begin
            found_o <= hit_any;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            entry_o <= hit_entry;  // zero on a miss
        end
    end

endmodule

`default_nettype wire

/* src/lsu_m1_ctrl.sv */
// loads and stores only without cacheop, LL/SC or barrier; msize is size minus one up to a word
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_m1_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       req_valid_i,
    output logic                            req_ready_o,
    input  wire logic [31:0]                req_vaddr_i,
    input  wire logic [3:0]                 req_wstrb_i,
    input  wire logic [31:0]                req_wdata_i,
    input  wire logic [1:0]                 req_msize_i,
    input  wire logic [1:0]                 cur_plv_i,
    input  wire logic                       tlb_found_i,
    input  wire lsu_pkg::tlb_entry_t        tlb_entry_i,
    input  wire logic                       stage_ready_i,
    output logic                            m1_valid_o,
    output logic [`LSU_SET_BITS-1:0]        set_index_o,
    output logic                            capture_o,
    output logic [19:0]                     m1_ppn_o,
    output logic [1:0]                      m1_word_o,
    output logic                            m1_write_o,
    output logic                            m1_uncached_o,
    output lsu_pkg::exc_code_e              m1_exc_o
);
    import lsu_pkg::*;

    logic                     raw_valid_q;
    logic                     skid_valid_q;
    logic                     skid_load;
    logic [`LSU_SET_BITS+3:0] raw_vaddr_q;
    logic [3:0]               skid_vaddr_q;
    logic [3:0]               sel_vaddr;
    logic [3:0]               raw_wstrb_q;
    logic [3:0]               skid_wstrb_q;
    logic [3:0]               sel_wstrb;
    logic [1:0]               raw_msize_q;
    logic [1:0]               skid_msize_q;
    logic [1:0]               sel_msize;
    logic                     skid_found_q;
    logic                     sel_found;
    logic                     sel_ale;
    tlb_entry_t               skid_entry_q;
    tlb_entry_t               sel_entry;

    assign req_ready_o = !skid_valid_q;
    // stalled M1 request moves aside so the next one can land in raw
    assign skid_load = raw_valid_q && !stage_ready_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raw_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            if (req_ready_o) begin
                raw_valid_q <= req_valid_i;
            end
            if (skid_valid_q) begin
                skid_valid_q <= !stage_ready_i;
            end else begin
                skid_valid_q <= skid_load;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            raw_vaddr_q <= req_vaddr_i[`LSU_SET_BITS+3:0];
            raw_wstrb_q <= req_wstrb_i;
            raw_msize_q <= req_msize_i;
        end
        if (skid_load) begin
            skid_vaddr_q <= raw_vaddr_q[3:0];
            skid_wstrb_q <= raw_wstrb_q;
            skid_msize_q <= raw_msize_q;
            skid_found_q <= tlb_found_i;   // TLB moves on to the next request
            skid_entry_q <= tlb_entry_i;
        end
    end

    // skid is older and goes first
    assign sel_vaddr = skid_valid_q ? skid_vaddr_q : raw_vaddr_q[3:0];
    assign sel_wstrb = skid_valid_q ? skid_wstrb_q : raw_wstrb_q;
    assign sel_msize = skid_valid_q ? skid_msize_q : raw_msize_q;
    assign sel_found = skid_valid_q ? skid_found_q : tlb_found_i;
    assign sel_entry = skid_valid_q ? skid_entry_q : tlb_entry_i;

    always_comb begin
        case (sel_msize)
            2'd0:    sel_ale = 1'b0;
            2'd1:    sel_ale = sel_vaddr[0];
            default: sel_ale = |sel_vaddr[1:0];
        endcase
        if (sel_ale) begin
            m1_exc_o = EXC_ALE;
        end else if (!sel_found) begin
            m1_exc_o = EXC_TLBR;
        end else if (!sel_entry.v) begin
            m1_exc_o = EXC_INV;
        end else if (sel_entry.plv == 2'd0 && cur_plv_i == 2'd3) begin
            m1_exc_o = EXC_PPI;
        end else if ((|sel_wstrb) && !sel_entry.d) begin
            m1_exc_o = EXC_PME;
        end else begin
            m1_exc_o = EXC_NONE;
        end
    end

    assign m1_valid_o    = skid_valid_q || raw_valid_q;
    // after the skid drains, the ways reread the set of the raw request
    assign set_index_o   = skid_valid_q ? raw_vaddr_q[`LSU_SET_BITS+3:4]
                                        : req_vaddr_i[`LSU_SET_BITS+3:4];
    assign capture_o     = skid_valid_q ? stage_ready_i : (!raw_valid_q || stage_ready_i);
    assign m1_ppn_o      = sel_entry.ppn;
    assign m1_word_o     = sel_vaddr[3:2];
    assign m1_write_o    = |sel_wstrb;
    assign m1_uncached_o = sel_entry.mat == 2'd0;

    a_skid_single: assert property (@(posedge clk) disable iff (!rst_n)
        skid_valid_q && !stage_ready_i |=> skid_valid_q
            && $stable({skid_vaddr_q, skid_wstrb_q, skid_msize_q, skid_found_q, skid_entry_q}));

    a_store_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && req_ready_o && (|req_wstrb_i) |-> !$isunknown(req_wdata_i));

endmodule

`default_nettype wire

/* src/dcache_way_probe.sv */
// storage is written only by snoop/refill; reads of a line never written return X data
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defines.svh"

module dcache_way_probe #(
    parameter int WAY_ID = 0
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [`LSU_SET_BITS-1:0]      set_index_i,
    input  wire logic                          capture_i,
    input  wire logic [19:0]                   ppn_i,
    input  wire logic [1:0]                    word_i,
    input  wire logic                          snoop_we_i,
    input  wire logic                          snoop_kind_i,
    input  wire logic [$clog2(`LSU_WAYS)-1:0]  snoop_way_i,
    input  wire logic [`LSU_SET_BITS-1:0]      snoop_index_i,
    input  wire logic [1:0]                    snoop_word_i,
    input  wire logic [3:0]                    snoop_strb_i,
    input  wire lsu_pkg::snoop_payload_u       snoop_payload_i,
    output logic                               way_hit_o,
    output logic [31:0]                        way_word_o
);
    import lsu_pkg::*;

    localparam int SETS = 1 << `LSU_SET_BITS;

    tag_entry_t               tag_mem [SETS];
    logic [SETS-1:0]          tag_valid_q;
    logic [3:0][31:0]         line_mem [SETS];
    logic                     tag_wr;
    logic                     data_wr;
    logic [`LSU_SET_BITS-1:0] held_index_q;
    logic [`LSU_SET_BITS-1:0] rd_index;
    tag_entry_t               held_tag_q;
    tag_entry_t               rd_tag;
    logic [3:0][31:0]         held_line_q;
    logic [3:0][31:0]         rd_line;

    assign tag_wr  = snoop_we_i && int'(snoop_way_i) == WAY_ID && snoop_kind_i;
    assign data_wr = snoop_we_i && int'(snoop_way_i) == WAY_ID && !snoop_kind_i;

    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[snoop_index_i] <= snoop_payload_i.tag;
        end
        if (data_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (snoop_strb_i[b]) begin
                    line_mem[snoop_index_i][snoop_word_i][8*b +: 8] <=
                        snoop_payload_i.word[8*b +: 8];
                end
            end
        end
    end

    // valid bits live apart so that reset invalidates the whole way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_valid_q <= '0;
        end else if (tag_wr) begin
            tag_valid_q[snoop_index_i] <= snoop_payload_i.tag.valid;
        end
    end

    // fresh read on capture, else keep the held copy; a snoop to that set merges in
    always_comb begin
        rd_index = capture_i ? set_index_i : held_index_q;
        rd_tag   = capture_i ? tag_mem[set_index_i] : held_tag_q;
        rd_line  = capture_i ? line_mem[set_index_i] : held_line_q;
        if (capture_i) begin
            rd_tag.valid = tag_valid_q[set_index_i];
        end
        if (snoop_index_i == rd_index) begin
            if (tag_wr) begin
                rd_tag = snoop_payload_i.tag;
            end
            if (data_wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (snoop_strb_i[b]) begin
                        rd_line[snoop_word_i][8*b +: 8] = snoop_payload_i.word[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        held_index_q <= rd_index;
        held_tag_q   <= rd_tag;
        held_line_q  <= rd_line;
    end

    assign way_hit_o  = held_tag_q.valid && held_tag_q.ppn == ppn_i;
    assign way_word_o = held_line_q[word_i];

endmodule

`default_nettype wire

/* src/lsu_resp_stage.sv */
// rdata is the raw aligned word, no byte/half extraction or sign extension
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_resp_stage (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            m1_valid_i,
    input  wire logic                            m1_write_i,
    input  wire logic                            m1_uncached_i,
    input  wire lsu_pkg::exc_code_e              m1_exc_i,
    input  wire logic [`LSU_WAYS-1:0]            way_hit_i,
    input  wire logic [`LSU_WAYS-1:0][31:0]      way_word_i,
    output logic                                 stage_ready_o,
    output logic                                 resp_valid_o,
    input  wire logic                            resp_ready_i,
    output logic                                 resp_hit_o,
    output logic [$clog2(`LSU_WAYS)-1:0]         resp_way_o,
    output logic [31:0]                          resp_rdata_o,
    output logic                                 resp_uncached_o,
    output lsu_pkg::exc_code_e                   resp_exc_o
);
    import lsu_pkg::*;

    localparam int WAY_BITS = $clog2(`LSU_WAYS);

    logic                no_exc;
    logic                cached_hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [31:0]         hit_word;

    // one-hot hits, so OR-ing is enough
    always_comb begin
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < `LSU_WAYS; w++) begin
            if (way_hit_i[w]) begin
                hit_way  = hit_way | WAY_BITS'(w);
                hit_word = hit_word | way_word_i[w];
            end
        end
    end

    assign no_exc        = m1_exc_i == EXC_NONE;
    assign cached_hit    = no_exc && !m1_uncached_i && (|way_hit_i);
    assign stage_ready_o = !resp_valid_o || resp_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
        end else if (stage_ready_o) begin
            resp_valid_o <= m1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_ready_o && m1_valid_i) begin
            resp_hit_o      <= cached_hit;
            resp_way_o      <= cached_hit ? hit_way : '0;
            resp_rdata_o    <= (cached_hit && !m1_write_i) ? hit_word : '0;  // stores get 0
            resp_uncached_o <= no_exc && m1_uncached_i;
            resp_exc_o      <= m1_exc_i;
        end
    end

    a_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        m1_valid_i |-> $onehot0(way_hit_i));

    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o
            && $stable({resp_hit_o, resp_way_o, resp_rdata_o, resp_uncached_o, resp_exc_o}));

endmodule

`default_nettype wire

/* src/lsu_m1_top.sv */
// hit/miss only, misses and refill are handled outside; privilege is a plain 2-bit level
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_m1_top (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 req_valid_i,
    output logic                                      req_ready_o,
    input  wire logic [31:0]                          req_vaddr_i,
    input  wire logic [3:0]                           req_wstrb_i,
    input  wire logic [31:0]                          req_wdata_i,
    input  wire logic [1:0]                           req_msize_i,
    input  wire logic [1:0]                           cur_plv_i,
    input  wire logic                                 tlb_we_i,
    input  wire logic [$clog2(`LSU_TLB_ENTRIES)-1:0]  tlb_idx_i,
    input  wire lsu_pkg::tlb_entry_t                  tlb_entry_i,
    input  wire logic                                 snoop_we_i,
    input  wire logic                                 snoop_kind_i,
    input  wire logic [$clog2(`LSU_WAYS)-1:0]         snoop_way_i,
    input  wire logic [`LSU_SET_BITS-1:0]             snoop_index_i,
    input  wire logic [1:0]                           snoop_word_i,
    input  wire logic [3:0]                           snoop_strb_i,
    input  wire lsu_pkg::snoop_payload_u              snoop_payload_i,
    output logic                                      resp_valid_o,
    input  wire logic                                 resp_ready_i,
    output logic                                      resp_hit_o,
    output logic [$clog2(`LSU_WAYS)-1:0]              resp_way_o,
    output logic [31:0]                               resp_rdata_o,
    output logic                                      resp_uncached_o,
    output lsu_pkg::exc_code_e                        resp_exc_o
);
    import lsu_pkg::*;

    logic                           tlb_found;
    tlb_entry_t                     tlb_entry;
    logic                           m1_valid;
    logic [`LSU_SET_BITS-1:0]       set_index;
    logic                           capture;
    logic [19:0]                    m1_ppn;
    logic [1:0]                     m1_word;
    logic                           m1_write;
    logic                           m1_uncached;
    exc_code_e                      m1_exc;
    logic                           stage_ready;
    logic [`LSU_WAYS-1:0]           way_hit;
    logic [`LSU_WAYS-1:0][31:0]     way_word;

    // TLB result belongs to the raw request, frozen while the skid is full
    lsu_addr_trans u_addr_trans (
        .clk         (clk),
        .rst_n       (rst_n),
        .vaddr_i     (req_vaddr_i),
        .tlb_we_i    (tlb_we_i),
        .tlb_idx_i   (tlb_idx_i),
        .tlb_entry_i (tlb_entry_i),
        .hold_i      (!req_ready_o),
        .found_o     (tlb_found),
        .entry_o     (tlb_entry)
    );

    lsu_m1_ctrl u_m1_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_vaddr_i   (req_vaddr_i),
        .req_wstrb_i   (req_wstrb_i),
        .req_wdata_i   (req_wdata_i),
        .req_msize_i   (req_msize_i),
        .cur_plv_i     (cur_plv_i),
        .tlb_found_i   (tlb_found),
        .tlb_entry_i   (tlb_entry),
        .stage_ready_i (stage_ready),
        .m1_valid_o    (m1_valid),
        .set_index_o   (set_index),
        .capture_o     (capture),
        .m1_ppn_o      (m1_ppn),
        .m1_word_o     (m1_word),
        .m1_write_o    (m1_write),
        .m1_uncached_o (m1_uncached),
        .m1_exc_o      (m1_exc)
    );

    for (genvar w = 0; w < `LSU_WAYS; w++) begin : g_way
        dcache_way_probe #(
            .WAY_ID (w)
        ) u_way (
            .clk             (clk),
            .rst_n           (rst_n),
            .set_index_i     (set_index),
            .capture_i       (capture),
            .ppn_i           (m1_ppn),
            .word_i          (m1_word),
            .snoop_we_i      (snoop_we_i),
            .snoop_kind_i    (snoop_kind_i),
            .snoop_way_i     (snoop_way_i),
            .snoop_index_i   (snoop_index_i),
            .snoop_word_i    (snoop_word_i),
            .snoop_strb_i    (snoop_strb_i),
            .snoop_payload_i (snoop_payload_i),
            .way_hit_o       (way_hit[w]),
            .way_word_o      (way_word[w])
        );
    end

    lsu_resp_stage u_resp_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .m1_valid_i      (m1_valid),
        .m1_write_i      (m1_write),
        .m1_uncached_i   (m1_uncached),
        .m1_exc_i        (m1_exc),
        .way_hit_i       (way_hit),
        .way_word_i      (way_word),
        .stage_ready_o   (stage_ready),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_hit_o      (resp_hit_o),
        .resp_way_o      (resp_way_o),
        .resp_rdata_o    (resp_rdata_o),
        .resp_uncached_o (resp_uncached_o),
        .resp_exc_o      (resp_exc_o)
    );

endmodule

`default_nettype wire

/* tests/lsu_m1_tb.sv */
// run from the project root; privilege changes and forced stalls first wait for an empty pipeline
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_m1_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int WAY_BITS   = $clog2(`LSU_WAYS);

    typedef struct packed {
        logic                hit;
        logic [WAY_BITS-1:0] way;
        logic [31:0]         rdata;
        logic                uncached;
        logic [2:0]          exc;
    } expect_t;

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    logic                                 req_valid_i;
    logic                                 req_ready_o;
    logic [31:0]                          req_vaddr_i;
    logic [3:0]                           req_wstrb_i;
    logic [31:0]                          req_wdata_i;
    logic [1:0]                           req_msize_i;
    logic [1:0]                           cur_plv_i;
    logic                                 tlb_we_i;
    logic [$clog2(`LSU_TLB_ENTRIES)-1:0]  tlb_idx_i;
    tlb_entry_t                           tlb_entry_i;
    logic                                 snoop_we_i;
    logic                                 snoop_kind_i;
    logic [WAY_BITS-1:0]                  snoop_way_i;
    logic [`LSU_SET_BITS-1:0]             snoop_index_i;
    logic [1:0]                           snoop_word_i;
    logic [3:0]                           snoop_strb_i;
    snoop_payload_u                       snoop_payload_i;
    logic                                 resp_valid_o;
    logic                                 resp_ready_i;
    logic                                 resp_hit_o;
    logic [WAY_BITS-1:0]                  resp_way_o;
    logic [31:0]                          resp_rdata_o;
    logic                                 resp_uncached_o;
    exc_code_e                            resp_exc_o;

    integer  seed = 96972;
    logic    stall_force = 1'b0;  // holds resp_ready_i low
    int      n_lines = 0;
    expect_t exp_q [$];
    string   lines [$];

    lsu_m1_top u_lsu_m1_top (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic check_response();
        expect_t e;
        if (exp_q.size() == 0) begin
            fail_run("a response came out with no request outstanding");
        end
        e = exp_q.pop_front();
        check_value("resp_hit_o", 32'(resp_hit_o), 32'(e.hit));
        check_value("resp_way_o", 32'(resp_way_o), 32'(e.way));
        check_value("resp_rdata_o", resp_rdata_o, e.rdata);
        check_value("resp_uncached_o", 32'(resp_uncached_o), 32'(e.uncached));
        check_value("resp_exc_o", 32'(resp_exc_o), 32'(e.exc));
    endtask

    // ready and the response check share one process, so the handshake is known here
    initial begin
        forever begin
            @(negedge clk);
            resp_ready_i = !stall_force && (($random(seed) & 3) != 0);
            if (resp_valid_o && resp_ready_i) begin
                check_response();
            end
        end
    end

    // every expected response taken
    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
    endtask

    task automatic load_tlb(input logic [31:0] idx, input logic [31:0] valid,
                            input logic [31:0] vppn, input logic [31:0] ppn,
                            input logic [31:0] v, input logic [31:0] d,
                            input logic [31:0] plv, input logic [31:0] mat);
        tlb_entry_t e;
        e.valid     = valid[0];
        e.vppn      = vppn[19:0];
        e.ppn       = ppn[19:0];
        e.v         = v[0];
        e.d         = d[0];
        e.plv       = plv[1:0];
        e.mat       = mat[1:0];
        tlb_idx_i   = idx[1:0];
        tlb_entry_i = e;
        tlb_we_i    = 1'b1;
        @(negedge clk);
        tlb_we_i = 1'b0;
    endtask

    task automatic write_snoop(input logic [31:0] kind, input logic [31:0] way,
                               input logic [31:0] index, input logic [31:0] word,
                               input logic [31:0] strb, input logic [31:0] payload);
        snoop_kind_i  = kind[0];
        snoop_way_i   = way[WAY_BITS-1:0];
        snoop_index_i = index[`LSU_SET_BITS-1:0];
        snoop_word_i  = word[1:0];
        snoop_strb_i  = strb[3:0];
        if (kind[0]) begin
            snoop_payload_i.tag = tag_entry_t'(payload);
        end else begin
            snoop_payload_i.word = payload;
        end
        snoop_we_i = 1'b1;
        @(negedge clk);
        snoop_we_i = 1'b0;
    endtask

    task automatic issue_request(input logic [31:0] vaddr, input logic [31:0] wstrb,
                                 input logic [31:0] wdata, input logic [31:0] msize,
                                 input logic [31:0] hit, input logic [31:0] way,
                                 input logic [31:0] rdata, input logic [31:0] unc,
                                 input logic [31:0] exc);
        expect_t e;
        e.hit       = hit[0];
        e.way       = way[WAY_BITS-1:0];
        e.rdata     = rdata;
        e.uncached  = unc[0];
        e.exc       = exc[2:0];
        req_vaddr_i = vaddr;
        req_wstrb_i = wstrb[3:0];
        req_wdata_i = wdata;
        req_msize_i = msize[1:0];
        req_valid_i = 1'b1;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        exp_q.push_back(e);  // taken on the coming rising edge
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    // M1 reads the privilege live, so nothing may be in flight
    task automatic set_privilege(input logic [31:0] plv);
        wait_idle();
        @(negedge clk);
        cur_plv_i = plv[1:0];
    endtask

    task automatic set_stall(input logic [31:0] on);
        if (on[0]) begin
            wait_idle();
        end else begin
            @(posedge clk);
        end
        stall_force = on[0];
        @(negedge clk);
    endtask

    task automatic run_line(input string line);
        string       cmd;
        string       rest;
        int          cnt;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7, f8;
        cmd  = line.substr(0, 0);
        rest = line.substr(1, line.len() - 1);
        if (line.len() < 2 || cmd == "#") begin
            cnt = 0;  // blank or comment
        end else if (cmd == "T") begin
            cnt = $sscanf(rest, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7);
            if (cnt != 8) begin
                fail_run({"badly formed TLB line: ", line});
            end
            load_tlb(f0, f1, f2, f3, f4, f5, f6, f7);
        end else if (cmd == "S") begin
            cnt = $sscanf(rest, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
            if (cnt != 6) begin
                fail_run({"badly formed snoop line: ", line});
            end
            write_snoop(f0, f1, f2, f3, f4, f5);
        end else if (cmd == "R") begin
            cnt = $sscanf(rest, "%h %h %h %h %h %h %h %h %h",
                          f0, f1, f2, f3, f4, f5, f6, f7, f8);
            if (cnt != 9) begin
                fail_run({"badly formed request line: ", line});
            end
            issue_request(f0, f1, f2, f3, f4, f5, f6, f7, f8);
        end else if (cmd == "L" || cmd == "P") begin
            cnt = $sscanf(rest, "%h", f0);
            if (cnt != 1) begin
                fail_run({"badly formed control line: ", line});
            end
            if (cmd == "L") begin
                set_privilege(f0);
            end else begin
                set_stall(f0);
            end
        end else begin
            fail_run({"unknown command in the test file: ", line});
        end
    endtask

    initial begin
        int    fd;
        string line;
        rst_n           = 1'b0;
        req_valid_i     = 1'b0;
        req_vaddr_i     = '0;
        req_wstrb_i     = '0;
        req_wdata_i     = '0;
        req_msize_i     = '0;
        cur_plv_i       = '0;
        tlb_we_i        = 1'b0;
        tlb_idx_i       = '0;
        tlb_entry_i     = '0;
        snoop_we_i      = 1'b0;
        snoop_kind_i    = 1'b0;
        snoop_way_i     = '0;
        snoop_index_i   = '0;
        snoop_word_i    = '0;
        snoop_strb_i    = '0;
        snoop_payload_i = '0;
        resp_ready_i    = 1'b0;
        fd = $fopen("tests/lsu_m1_tests.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/lsu_m1_tests.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        n_lines = lines.size();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("req_ready_o", 32'(req_ready_o), 32'd1);  // idle after reset
        check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        wait_idle();
        repeat (10) @(negedge clk);  // any late extra response trips check_response
        $display("All tests passed");
        $finish;
    end

    // 40 cycles per file line
    initial begin
        wait (n_lines > 0);
        #(n_lines * 40 * CLK_PERIOD);
        fail_run($sformatf("the run hung and did not finish within %0d cycles", n_lines * 40));
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_addr_trans.sv
src/lsu_m1_ctrl.sv
src/dcache_way_probe.sv
src/lsu_resp_stage.sv
src/lsu_m1_top.sv
tests/lsu_m1_tb.sv

/* Makefile */
TOP := lsu_m1_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module lsu_m1_top

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* tests/lsu_m1_tests.txt */
# T idx valid vppn ppn v d plv mat | S kind(1 tag) way index word strb payload | L plv
# R vaddr wstrb wdata msize exp_hit exp_way exp_rdata exp_uncached exp_exc | P 1/0 hold resp_ready
T 0 1 00010 12345 1 1 3 1
T 1 1 00020 0abcd 1 1 3 0
T 2 1 00030 00777 0 1 3 1
T 3 1 00040 00888 1 0 0 1
S 1 2 05 0 0 80012345
S 0 2 05 1 f 11112222
S 0 2 05 3 f 33334444
S 1 0 05 0 0 80099999
S 1 1 07 0 0 80012345
S 0 1 07 0 f cafef00d
S 1 3 09 0 0 00012345
S 1 0 0a 0 0 8000abcd
S 0 0 0a 0 f 0badf00d
S 0 3 0c 2 f 5a5a0001
R 00010054 0 00000000 2 1 2 11112222 0 0
R 0001005c 0 00000000 2 1 2 33334444 0 0
R 00010070 0 00000000 2 1 1 cafef00d 0 0
R 00010055 0 00000000 0 1 2 11112222 0 0
R 00010090 0 00000000 2 0 0 00000000 0 0
R 000100b0 0 00000000 2 0 0 00000000 0 0
R 000200a0 0 00000000 2 0 0 00000000 1 0
R 00010054 f deadbeef 2 1 2 00000000 0 0
R 00050002 0 00000000 2 0 0 00000000 0 1
R 00010055 0 00000000 1 0 0 00000000 0 1
R 00050000 0 00000000 2 0 0 00000000 0 2
R 00030000 0 00000000 2 0 0 00000000 0 3
L 3
R 00040000 0 00000000 2 0 0 00000000 0 4
L 0
R 00040000 1 000000aa 0 0 0 00000000 0 5
R 00040000 0 00000000 2 0 0 00000000 0 0
P 1
R 000100b0 0 00000000 2 0 0 00000000 0 0
R 00010054 0 00000000 2 1 2 11bb22dd 0 0
S 0 2 05 1 5 aabbccdd
P 0
P 1
R 000100b0 0 00000000 2 0 0 00000000 0 0
R 000100c8 0 00000000 2 1 3 5a5a0001 0 0
S 1 3 0c 0 0 80012345
P 0
